/* Makefile */
# Verilator build and run of the decode stage testbench
VERILATOR = verilator
FLAGS     = --binary --assert --timing
TOP       = tb_decode_stage
FILELIST  = vlog.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf $(BUILD_DIR)

/* dec_fields_if.sv */
// decoded field bundle: field decoder to hazard unit and stage register
interface dec_fields_if #(
    parameter int XLEN = 64
);

    // register numbers straight from the word
    logic [decode_pkg::REG_ADDR_W-1:0] rs1;
    logic [decode_pkg::REG_ADDR_W-1:0] rs2;
    logic [decode_pkg::REG_ADDR_W-1:0] rd;
    // which sources the format really reads
    logic                              uses_rs1;
    logic                              uses_rs2;
    decode_pkg::dec_op_t               op;
    // sign-extended immediate
    logic [XLEN-1:0]                   imm;
    // opcode is one of the thirteen groups
    logic                              legal;

    modport producer (output rs1, rs2, rd, uses_rs1, uses_rs2, op, imm, legal);
    modport hazard (input rs1, rs2, uses_rs1, uses_rs2);
    modport stage (input rd, op, imm, legal);

endinterface

/* decode_pkg.sv */
// decode package: widths, opcode encodings, instruction views, decoded op, bubble value
package decode_pkg;

    // base widths of the decode stage
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opc_op        = 7'b0110011,
        opc_op_32     = 7'b0111011,
        opc_jalr      = 7'b1100111,
        opc_load      = 7'b0000011,
        opc_op_imm    = 7'b0010011,
        opc_op_imm_32 = 7'b0011011,
        opc_store     = 7'b0100011,
        opc_branch    = 7'b1100011,
        opc_lui       = 7'b0110111,
        opc_auipc     = 7'b0010111,
        opc_jal       = 7'b1101111,
        opc_misc_mem  = 7'b0001111,
        opc_system    = 7'b1110011
    } opcode_e;

    // operation handed to execute, {funct3, opcode}
    typedef struct packed {
        logic [2:0] funct3;
        logic [6:0] opcode;
    } dec_op_t;

    // register view of the word
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_type_t;

    // store/branch view
    // imm pieces sit where funct7 and rd are in the register view
    typedef struct packed {
        logic                  imm_sign;
        logic [5:0]            imm_mid;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_lo;
        logic                  imm_b11;
        logic [6:0]            opcode;
    } sb_type_t;

    // one instruction word, two ways to read it
    typedef union packed {
        r_type_t  r;
        sb_type_t sb;
    } instr_u;

    // bubble looks like a fence with funct3 zero
    localparam dec_op_t BUBBLE_OP = '{funct3: 3'b000, opcode: opc_misc_mem};

endpackage

/* decode_stage.sv */
// decode stage top: field decoder, hazard unit, register file, stage register
module decode_stage #(
    parameter int XLEN = 64
) (
    input  logic                              clk,
    input  logic                              reset,
    // from fetch
    input  logic [decode_pkg::ILEN-1:0]       instr,
    input  logic                              instr_valid,
    input  logic [XLEN-1:0]                   pc,
    // taken jump squashes this cycle
    input  logic                              flush,
    // destinations in flight
    input  logic [decode_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic                              ex_store,
    input  logic [decode_pkg::REG_ADDR_W-1:0] mem_rd,
    input  logic [decode_pkg::REG_ADDR_W-1:0] wb_rd,
    // writeback port
    input  logic                              wr_en,
    input  logic [decode_pkg::REG_ADDR_W-1:0] wr_reg,
    input  logic [XLEN-1:0]                   wr_data,
    // back to fetch, same cycle
    output logic                              stall,
    // to execute
    output logic                              dec_valid,
    output decode_pkg::dec_op_t               dec_op,
    output logic [decode_pkg::REG_ADDR_W-1:0] dec_rd,
    output logic [XLEN-1:0]                   dec_rs1_data,
    output logic [XLEN-1:0]                   dec_rs2_data,
    output logic [XLEN-1:0]                   dec_imm,
    output logic [XLEN-1:0]                   dec_pc,
    output logic [decode_pkg::ILEN-1:0]       dec_instr
);

    dec_fields_if #(.XLEN(XLEN)) fields_if ();
    regfile_rd_if #(.XLEN(XLEN)) rf_if ();

    instr_field_decode i_field_decode (
        .instr  (instr),
        .fields (fields_if)
    );

    // unused sources read x0, so their data is zero
    assign rf_if.addr_a = fields_if.uses_rs1 ? fields_if.rs1 : '0;
    assign rf_if.addr_b = fields_if.uses_rs2 ? fields_if.rs2 : '0;

    hazard_detect i_hazard (
        .fields      (fields_if),
        .instr_valid (instr_valid),
        .ex_rd       (ex_rd),
        .ex_store    (ex_store),
        .mem_rd      (mem_rd),
        .wb_rd       (wb_rd),
        .stall       (stall)
    );

    register_file #(.XLEN(XLEN)) i_regfile (
        .clk     (clk),
        .reset   (reset),
        .rd      (rf_if),
        .wr_en   (wr_en),
        .wr_reg  (wr_reg),
        .wr_data (wr_data)
    );

    decode_stage_reg #(.XLEN(XLEN)) i_stage_reg (
        .clk          (clk),
        .reset        (reset),
        .fields       (fields_if),
        .rd           (rf_if),
        .instr        (instr),
        .pc           (pc),
        .instr_valid  (instr_valid),
        .stall        (stall),
        .flush        (flush),
        .dec_valid    (dec_valid),
        .dec_op       (dec_op),
        .dec_rd       (dec_rd),
        .dec_rs1_data (dec_rs1_data),
        .dec_rs2_data (dec_rs2_data),
        .dec_imm      (dec_imm),
        .dec_pc       (dec_pc),
        .dec_instr    (dec_instr)
    );

endmodule

/* decode_stage_reg.sv */
// decode/execute pipeline register with bubble insertion on stall, flush or bad input
module decode_stage_reg #(
    parameter int XLEN = 64
) (
    input  logic                              clk,
    input  logic                              reset,
    dec_fields_if.stage                       fields,
    regfile_rd_if.reader                      rd,
    input  logic [decode_pkg::ILEN-1:0]       instr,
    input  logic [XLEN-1:0]                   pc,
    input  logic                              instr_valid,
    input  logic                              stall,
    input  logic                              flush,
    output logic                              dec_valid,
    output decode_pkg::dec_op_t               dec_op,
    output logic [decode_pkg::REG_ADDR_W-1:0] dec_rd,
    output logic [XLEN-1:0]                   dec_rs1_data,
    output logic [XLEN-1:0]                   dec_rs2_data,
    output logic [XLEN-1:0]                   dec_imm,
    output logic [XLEN-1:0]                   dec_pc,
    output logic [decode_pkg::ILEN-1:0]       dec_instr
);

    logic accept;

    // instruction leaves fetch this edge
    assign accept = instr_valid && fields.legal && !stall && !flush;

    // control and operands
    // a bubble is the same state as right after reset
    always_ff @(posedge clk) begin
        if (reset || !accept) begin
            dec_valid    <= 1'b0;
            dec_op       <= decode_pkg::BUBBLE_OP;
            // zero rd so nothing downstream writes back
            dec_rd       <= '0;
            dec_rs1_data <= '0;
            dec_rs2_data <= '0;
            dec_imm      <= '0;
        end else begin
            dec_valid    <= 1'b1;
            dec_op       <= fields.op;
            dec_rd       <= fields.rd;
            dec_rs1_data <= rd.data_a;
            dec_rs2_data <= rd.data_b;
            dec_imm      <= fields.imm;
        end
    end

    // pc and raw word ride along every cycle
    // dec_valid tells execute whether they mean anything
    always_ff @(posedge clk) begin
        dec_pc    <= pc;
        dec_instr <= instr;
    end

    // jump squash reaches execute as a bubble one edge later
    flush_bubble_a: assert property (
        @(posedge clk) disable iff (reset)
        flush |=> !dec_valid
    ) else $error("flushed instruction reached execute");

endmodule

/* decode_trace.txt */
# instr valid pc flush ex_rd ex_store mem_rd wb_rd wr_en wr_reg wr_data, all hex
# then expected: stall dec_valid dec_op dec_rd dec_rs1_data dec_rs2_data dec_imm
# registers read zero after reset
002082b3 1 1000 0 00 0 00 00 0 00 0 0 1 033 05 0 0 0
# writeback port, the x0 write is dropped
00000000 0 1004 0 00 0 00 00 1 01 123456789abcdef 0 0 00f 00 0 0 0
00000000 0 1004 0 00 0 00 00 1 02 fedcba9876543210 0 0 00f 00 0 0 0
00000000 0 1004 0 00 0 00 00 1 00 dead 0 0 00f 00 0 0 0
00000000 0 1004 0 00 0 00 00 1 03 55 0 0 00f 00 0 0 0
# operand reads through op and op_32
002082b3 1 1004 0 00 0 00 00 0 00 0 0 1 033 05 123456789abcdef fedcba9876543210 0
003003b3 1 1008 0 00 0 00 00 0 00 0 0 1 033 07 0 55 0
0020843b 1 100c 0 00 0 00 00 0 00 0 0 1 03b 08 123456789abcdef fedcba9876543210 0
001134b3 1 1010 0 00 0 00 00 0 00 0 0 1 1b3 09 fedcba9876543210 123456789abcdef 0
# I format: addi, ld, addiw, jalr, csrrw
fff08513 1 1014 0 00 0 00 00 0 00 0 0 1 013 0a 123456789abcdef 0 ffffffffffffffff
0101b583 1 1018 0 00 0 00 00 0 00 0 0 1 183 0b 55 0 10
7ff1061b 1 101c 0 00 0 00 00 0 00 0 0 1 01b 0c fedcba9876543210 0 7ff
ffc186e7 1 1020 0 00 0 00 00 0 00 0 0 1 067 0d 55 0 fffffffffffffffc
30009773 1 1024 0 00 0 00 00 0 00 0 0 1 0f3 0e 123456789abcdef 0 300
# S and B formats
fe20bc23 1 1028 0 00 0 00 00 0 00 0 0 1 1a3 00 123456789abcdef fedcba9876543210 fffffffffffffff8
123121a3 1 102c 0 00 0 00 00 0 00 0 0 1 123 00 fedcba9876543210 55 123
fe2088e3 1 1030 0 00 0 00 00 0 00 0 0 1 063 00 123456789abcdef fedcba9876543210 fffffffffffffff0
04314063 1 1034 0 00 0 00 00 0 00 0 0 1 263 00 fedcba9876543210 55 40
# U and J formats, fence
800007b7 1 1038 0 00 0 00 00 0 00 0 0 1 037 0f 0 0 ffffffff80000000
12345817 1 103c 0 00 0 00 00 0 00 0 0 1 297 10 0 0 12345000
100008ef 1 1040 0 00 0 00 00 0 00 0 0 1 06f 11 0 0 100
ffdff06f 1 1044 0 00 0 00 00 0 00 0 0 1 06f 00 0 0 fffffffffffffffc
0ff0000f 1 1048 0 00 0 00 00 0 00 0 0 1 00f 00 0 0 0
# RAW hazards on mem_rd, wb_rd, ex_rd, then a store in execute
002082b3 1 104c 0 00 0 01 00 0 00 0 1 0 00f 00 0 0 0
002082b3 1 104c 0 00 0 00 02 0 00 0 1 0 00f 00 0 0 0
002082b3 1 104c 0 01 0 00 00 0 00 0 1 0 00f 00 0 0 0
002082b3 1 104c 0 02 1 00 00 0 00 0 0 1 033 05 123456789abcdef fedcba9876543210 0
# unused source fields match destinations, empty slot never stalls
123457b7 1 1050 0 08 0 03 08 0 00 0 0 1 2b7 0f 0 0 12345000
000288ef 1 1054 0 00 0 05 00 0 00 0 0 1 06f 11 0 0 28000
002082b3 0 1058 0 00 0 01 02 0 00 0 0 0 00f 00 0 0 0
# flush and an illegal opcode give bubbles, then recovery
002082b3 1 105c 1 00 0 00 00 0 00 0 0 0 00f 00 0 0 0
ffffffff 1 1060 0 00 0 1f 1f 0 00 0 0 0 00f 00 0 0 0
002082b3 1 1064 0 00 0 00 00 0 00 0 0 1 033 05 123456789abcdef fedcba9876543210 0

/* hazard_detect.sv */
// RAW and load-use hazard check against execute, memory and writeback destinations
module hazard_detect (
    dec_fields_if.hazard                     fields,
    input  logic                             instr_valid,
    input  logic [decode_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic                             ex_store,
    input  logic [decode_pkg::REG_ADDR_W-1:0] mem_rd,
    input  logic [decode_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic                             stall
);

    logic rs1_hit;
    logic rs2_hit;

    // source pending in a later stage
    // x0 never waits, a store in execute has no destination
    function automatic logic pending(input logic used,
                                     input logic [decode_pkg::REG_ADDR_W-1:0] src);
        logic in_flight;
        in_flight = ((src == ex_rd) && !ex_store) || (src == mem_rd) || (src == wb_rd);
        return used && (src != '0) && in_flight;
    endfunction

    always_comb begin
        rs1_hit = pending(fields.uses_rs1, fields.rs1);
        rs2_hit = pending(fields.uses_rs2, fields.rs2);
    end

    // fetch holds while this is high
    assign stall = instr_valid && (rs1_hit || rs2_hit);

endmodule

/* instr_field_decode.sv */
// combinational field decoder: formats, source usage, destination, immediate
module instr_field_decode (
    input  logic [decode_pkg::ILEN-1:0] instr,
    dec_fields_if.producer              fields
);

    // immediate width follows the bundle, so XLEN 32 and 64 both work
    localparam int XW = $bits(fields.imm);

    decode_pkg::instr_u                 word;
    logic signed [decode_pkg::ILEN-1:0] imm32;

    always_comb begin
        word = instr;

        // defaults: register fields read through the R view
        fields.rs1         = word.r.rs1;
        fields.rs2         = word.r.rs2;
        fields.rd          = word.r.rd;
        fields.op.funct3   = word.r.funct3;
        fields.op.opcode   = word.r.opcode;
        fields.uses_rs1    = 1'b0;
        fields.uses_rs2    = 1'b0;
        fields.legal       = 1'b1;
        // R format has no immediate
        imm32              = '0;

        case (word.r.opcode)
            decode_pkg::opc_op,
            decode_pkg::opc_op_32: begin
                fields.uses_rs1 = 1'b1;
                fields.uses_rs2 = 1'b1;
            end
            decode_pkg::opc_load,
            decode_pkg::opc_op_imm,
            decode_pkg::opc_op_imm_32,
            decode_pkg::opc_jalr,
            decode_pkg::opc_system: begin
                // I format, 12 bits from the top
                fields.uses_rs1 = 1'b1;
                imm32           = {{20{instr[31]}}, instr[31:20]};
            end
            decode_pkg::opc_store: begin
                // S format via the split view, no destination
                fields.uses_rs1 = 1'b1;
                fields.uses_rs2 = 1'b1;
                fields.rd       = '0;
                imm32 = {{20{word.sb.imm_sign}}, word.sb.imm_sign, word.sb.imm_mid,
                         word.sb.imm_lo, word.sb.imm_b11};
            end
            decode_pkg::opc_branch: begin
                // B format, same pieces reordered, bit 0 zero
                fields.uses_rs1 = 1'b1;
                fields.uses_rs2 = 1'b1;
                fields.rd       = '0;
                imm32 = {{19{word.sb.imm_sign}}, word.sb.imm_sign, word.sb.imm_b11,
                         word.sb.imm_mid, word.sb.imm_lo, 1'b0};
            end
            decode_pkg::opc_lui,
            decode_pkg::opc_auipc: begin
                // U format, upper 20 bits
                imm32 = {instr[31:12], 12'b0};
            end
            decode_pkg::opc_jal: begin
                // bits 14:12 belong to the jump offset here
                fields.op.funct3 = '0;
                // J format, scrambled 20 bits plus a zero
                imm32 = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                         instr[30:21], 1'b0};
            end
            decode_pkg::opc_misc_mem: begin
                // fence writes nothing and reads nothing
                fields.rd = '0;
            end
            default: begin
                // unknown opcode, stage register turns it into a bubble
                fields.legal = 1'b0;
                fields.rd    = '0;
            end
        endcase

        // RV64 sign-extends every format from bit 31
        fields.imm = XW'(imm32);
    end

    // a legal decode always carries a known operation
    always_comb begin
        if (fields.legal) begin
            op_known_a: assert (!$isunknown(fields.op))
                else $error("decoded op unknown for a legal opcode");
        end
    end

endmodule

/* regfile_rd_if.sv */
// register file read port pair: addresses in, operand data out
interface regfile_rd_if #(
    parameter int XLEN = 64
);

    // port a serves rs1, port b serves rs2
    logic [decode_pkg::REG_ADDR_W-1:0] addr_a;
    logic [decode_pkg::REG_ADDR_W-1:0] addr_b;
    logic [XLEN-1:0]                   data_a;
    logic [XLEN-1:0]                   data_b;

    // array side
    modport file (input addr_a, addr_b, output data_a, data_b);
    // stage register only samples the data
    modport reader (input data_a, data_b);

endinterface

/* register_file.sv */
// 32-entry integer register file: two async read ports, one sync write, x0 zero
module register_file #(
    parameter int XLEN = 64
) (
    input  logic                             clk,
    input  logic                             reset,
    regfile_rd_if.file                       rd,
    input  logic                             wr_en,
    input  logic [decode_pkg::REG_ADDR_W-1:0] wr_reg,
    input  logic [XLEN-1:0]                  wr_data
);

    logic [XLEN-1:0] regs [decode_pkg::NUM_REGS];

    // writeback port
    // visible to reads right after the edge, no bypass
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < decode_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_reg != '0)) begin
            // x0 stays zero since it is never written
            regs[wr_reg] <= wr_data;
        end
    end

    // operand reads, same cycle
    assign rd.data_a = regs[rd.addr_a];
    assign rd.data_b = regs[rd.addr_b];

    // x0 holds zero through reset and any writeback traffic
    x0_zero_a: assert property (
        @(posedge clk) disable iff (reset)
        (rd.addr_a == '0) |-> (rd.data_a == '0)
    ) else $error("register x0 read back nonzero");

endmodule

/* tb_decode_stage.sv */
// testbench for the decode stage: trace reader, input driver, output checks, summary
module tb_decode_stage;

    localparam int XLEN          = 64;
    localparam int NUM_COLS      = 18;
    localparam int MAX_TESTS     = 64;
    localparam int MIN_TESTS     = 20;
    localparam int RESET_TIMEOUT = 20;
    // misc_mem opcode with funct3 zero
    localparam logic [63:0] BUBBLE_WORD = 64'h00f;
    // add x5, x1, x2
    localparam logic [31:0] RESET_WORD  = 32'h002082b3;

    // trace columns, inputs first
    localparam int C_INSTR   = 0;
    localparam int C_VALID   = 1;
    localparam int C_PC      = 2;
    localparam int C_FLUSH   = 3;
    localparam int C_EX_RD   = 4;
    localparam int C_EX_ST   = 5;
    localparam int C_MEM_RD  = 6;
    localparam int C_WB_RD   = 7;
    localparam int C_WR_EN   = 8;
    localparam int C_WR_REG  = 9;
    localparam int C_WR_DATA = 10;
    // expected values
    localparam int C_STALL   = 11;
    localparam int C_DVALID  = 12;
    localparam int C_OP      = 13;
    localparam int C_RD      = 14;
    localparam int C_RS1     = 15;
    localparam int C_RS2     = 16;
    localparam int C_IMM     = 17;

    logic                clk;
    logic                reset;
    logic [31:0]         instr;
    logic                instr_valid;
    logic [XLEN-1:0]     pc;
    logic                flush;
    logic [4:0]          ex_rd;
    logic                ex_store;
    logic [4:0]          mem_rd;
    logic [4:0]          wb_rd;
    logic                wr_en;
    logic [4:0]          wr_reg;
    logic [XLEN-1:0]     wr_data;
    logic                stall;
    logic                dec_valid;
    decode_pkg::dec_op_t dec_op;
    logic [4:0]          dec_rd;
    logic [XLEN-1:0]     dec_rs1_data;
    logic [XLEN-1:0]     dec_rs2_data;
    logic [XLEN-1:0]     dec_imm;
    logic [XLEN-1:0]     dec_pc;
    logic [31:0]         dec_instr;

    // one row per cycle of stimulus
    logic [63:0] trace [MAX_TESTS][NUM_COLS];
    int          n_tests;
    bit          trace_ok;
    bit          test_ok;
    int          pass_count;
    int          fail_count;

    decode_stage #(.XLEN(XLEN)) i_decode_stage (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .pc           (pc),
        .flush        (flush),
        .ex_rd        (ex_rd),
        .ex_store     (ex_store),
        .mem_rd       (mem_rd),
        .wb_rd        (wb_rd),
        .wr_en        (wr_en),
        .wr_reg       (wr_reg),
        .wr_data      (wr_data),
        .stall        (stall),
        .dec_valid    (dec_valid),
        .dec_op       (dec_op),
        .dec_rd       (dec_rd),
        .dec_rs1_data (dec_rs1_data),
        .dec_rs2_data (dec_rs2_data),
        .dec_imm      (dec_imm),
        .dec_pc       (dec_pc),
        .dec_instr    (dec_instr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for five rising edges, dropped on a falling edge
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

    // comment lines give zero matches and are skipped
    task automatic read_trace();
        int          fd;
        int          code;
        int          line_no;
        bit          bad_line;
        string       line;
        logic [63:0] col [NUM_COLS];
        n_tests  = 0;
        line_no  = 0;
        bad_line = 1'b0;
        trace_ok = 1'b0;
        fd = $fopen("decode_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file decode_trace.txt");
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                code = $fgets(line, fd);
                line_no++;
                if (code != 0) begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   col[0], col[1], col[2], col[3], col[4], col[5],
                                   col[6], col[7], col[8], col[9], col[10], col[11],
                                   col[12], col[13], col[14], col[15], col[16], col[17]);
                    if (code == NUM_COLS) begin
                        for (int c = 0; c < NUM_COLS; c++) begin
                            trace[n_tests][c] = col[c];
                        end
                        n_tests++;
                    end else if (code > 0) begin
                        $display("trace line %0d holds only %0d of %0d columns",
                                 line_no, code, NUM_COLS);
                        bad_line = 1'b1;
                    end
                end
            end
            $fclose(fd);
            if (n_tests < MIN_TESTS) begin
                $display("trace file is too short, %0d tests where %0d are needed",
                         n_tests, MIN_TESTS);
            end else if (!bad_line) begin
                trace_ok = 1'b1;
            end
        end
    endtask

    task automatic drive_inputs(input int t);
        instr       = trace[t][C_INSTR][31:0];
        instr_valid = trace[t][C_VALID][0];
        pc          = trace[t][C_PC];
        flush       = trace[t][C_FLUSH][0];
        ex_rd       = trace[t][C_EX_RD][4:0];
        ex_store    = trace[t][C_EX_ST][0];
        mem_rd      = trace[t][C_MEM_RD][4:0];
        wb_rd       = trace[t][C_WB_RD][4:0];
        wr_en       = trace[t][C_WR_EN][0];
        wr_reg      = trace[t][C_WR_REG][4:0];
        wr_data     = trace[t][C_WR_DATA];
    endtask

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        field_a: assert (got === exp)
            else begin
                $display("Error: %0t: %s is %h, expected %h", $time, name, got, exp);
                test_ok = 1'b0;
            end
    endtask

    task automatic finish_test(input string name);
        if (test_ok) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: mismatch", name);
        end
    endtask

    // outputs after a reset edge, with a legal word presented as valid
    task automatic check_reset_state();
        test_ok = 1'b1;
        check_field("stall", 64'(stall), 64'd0);
        check_field("dec_valid", 64'(dec_valid), 64'd0);
        check_field("dec_op", 64'(dec_op), BUBBLE_WORD);
        check_field("dec_rd", 64'(dec_rd), 64'd0);
        check_field("dec_rs1_data", 64'(dec_rs1_data), 64'd0);
        check_field("dec_rs2_data", 64'(dec_rs2_data), 64'd0);
        check_field("dec_imm", 64'(dec_imm), 64'd0);
        finish_test("test reset");
    endtask

    // inputs still held, so stall still belongs to row t
    task automatic check_outputs(input int t);
        test_ok = 1'b1;
        check_field("stall", 64'(stall), trace[t][C_STALL]);
        check_field("dec_valid", 64'(dec_valid), trace[t][C_DVALID]);
        check_field("dec_op", 64'(dec_op), trace[t][C_OP]);
        check_field("dec_rd", 64'(dec_rd), trace[t][C_RD]);
        check_field("dec_rs1_data", 64'(dec_rs1_data), trace[t][C_RS1]);
        check_field("dec_rs2_data", 64'(dec_rs2_data), trace[t][C_RS2]);
        check_field("dec_imm", 64'(dec_imm), trace[t][C_IMM]);
        // pc and raw word only carry meaning in a valid slot
        if (trace[t][C_DVALID][0]) begin
            check_field("dec_pc", 64'(dec_pc), trace[t][C_PC]);
            check_field("dec_instr", 64'(dec_instr), trace[t][C_INSTR]);
        end
        finish_test($sformatf("test %0d", t + 1));
    endtask

    initial begin : main
        int waited;
        // valid legal word during reset, only reset can turn it into a bubble
        instr       = RESET_WORD;
        instr_valid = 1'b1;
        pc          = '0;
        flush       = 1'b0;
        ex_rd       = '0;
        ex_store    = 1'b0;
        mem_rd      = '0;
        wb_rd       = '0;
        wr_en       = 1'b0;
        wr_reg      = '0;
        wr_data     = '0;
        pass_count  = 0;
        fail_count  = 0;
        read_trace();
        // first reset edge done, reset still high
        @(negedge clk);
        check_reset_state();
        instr       = '0;
        instr_valid = 1'b0;
        waited = 0;
        // reset drops on a falling edge, so look for it on rising ones
        while (reset !== 1'b0 && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!trace_ok) begin
            $display("Test failed");
        end else if (reset !== 1'b0) begin
            $display("reset was still high after %0d cycles", RESET_TIMEOUT);
            $display("Test failed");
        end else begin
            @(negedge clk);
            for (int t = 0; t < n_tests; t++) begin
                drive_inputs(t);
                @(negedge clk);
                check_outputs(t);
            end
            $display("%0d tests, %0d passed, %0d failed",
                     pass_count + fail_count, pass_count, fail_count);
            if (fail_count == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
        end
        $finish;
    end

endmodule

/* vlog.f */
decode_pkg.sv
dec_fields_if.sv
regfile_rd_if.sv
instr_field_decode.sv
hazard_detect.sv
register_file.sv
decode_stage_reg.sv
decode_stage.sv
tb_decode_stage.sv
